// ==== vlog.f ====
+incdir+hw
hw/ifu_pkg.sv
hw/ifu_minidec.sv
hw/ifu_bpu.sv
hw/ifu_ifetch.sv
hw/ifu_itcm.sv
hw/ifu_top.sv
verif/ifu_sva.sv
verif/ifu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ifu_tb \
   -f vlog.f -o ifu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/ifu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

// ==== verif/ifu_tb.sv ====
`timescale 1ns/100ps
`include "ifu_settings.svh"

module ifu_tb;
   import ifu_pkg::*;

   localparam xlen_t X1_VAL  = 32'h0000_0080;
   localparam xlen_t RS1_VAL = 32'h0000_00c0;
   localparam int    N_TOTAL = 16 + 24 + 8 + 24 + 22 + 60;
   localparam int    LIMIT   = 20 * N_TOTAL + 200;

   logic      clk = 1'b0;
   logic      rst_n;
   logic      imem_wr;
   pc_t       imem_wr_addr;
   rv_instr_u imem_wr_data;
   rv_instr_u ifu_o_ir;
   pc_t       ifu_o_pc;
   rfidx_t    ifu_o_rs1idx;
   rfidx_t    ifu_o_rs2idx;
   logic      ifu_o_prdt_taken;
   logic      ifu_o_valid;
   logic      ifu_o_ready;
   logic      pipe_flush_ack;
   logic      pipe_flush_req;
   pc_t       pipe_flush_add_op1;
   pc_t       pipe_flush_add_op2;
   logic      oitf_empty;
   logic      dec2ifu_rden;
   rfidx_t    dec2ifu_rdidx;
   xlen_t     rf2ifu_x1;
   xlen_t     rf2ifu_rs1;

   integer      seed;
   int          err_cnt = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          got_cnt = 0;
   int          cycles = 0;
   logic [1:0]  ready_mode;      // 0 low, 1 high, 2 random
   logic [31:0] prog [0:`IFU_ITCM_DEPTH-1];
   pc_t         exp_pc_q [$];
   rv_instr_u   exp_ir_q [$];
   pc_t         e_pc;
   rv_instr_u   e_ir;

   ifu_top u_dut (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] enc_i(logic [11:0] imm, rfidx_t rs1, rfidx_t rd,
                                         logic [6:0] opc);
      return {imm, rs1, 3'b000, rd, opc};
   endfunction

   function automatic logic [31:0] enc_r(rfidx_t rs2, rfidx_t rs1, rfidx_t rd);
      return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] imm, rfidx_t rs1, rfidx_t rs2);
      return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] imm, rfidx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // static prediction as the execute side expects it
   function automatic pc_t ref_next_pc(rv_instr_u w, pc_t pc);
      logic [31:0] b;
      pc_t         nxt;
      b = w;
      case (b[6:0])
         7'b1101111: nxt = pc + {{11{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
         7'b1100111: begin
            nxt = {{20{b[31]}}, b[31:20]};
            if (b[19:15] == 5'd1) nxt = nxt + X1_VAL;
            else if (b[19:15] != 5'd0) nxt = nxt + RS1_VAL;
         end
         7'b1100011: nxt = b[31] ? pc + {{19{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0}
                                 : pc + 4;
         default:    nxt = pc + 4;
      endcase
      return {nxt[31:2], 2'b00};
   endfunction

   function automatic logic ref_taken(rv_instr_u w);
      logic [31:0] b;
      b = w;
      return (b[6:0] == 7'b1101111) || (b[6:0] == 7'b1100111)
          || ((b[6:0] == 7'b1100011) && b[31]);
   endfunction

   function automatic rfidx_t ref_rs1(rv_instr_u w);
      logic [31:0] b;
      b = w;
      return (b[6:0] == 7'b1101111) ? 5'd0 : b[19:15];
   endfunction

   function automatic rfidx_t ref_rs2(rv_instr_u w);
      logic [31:0] b;
      b = w;
      return (b[6:0] == 7'b1100011) ? b[24:20] : 5'd0;
   endfunction

   task automatic check_pc(string name, pc_t got, pc_t exp);
      if (got !== exp) begin
         $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_instr(string name, rv_instr_u got, rv_instr_u exp);
      if (got !== exp) begin
         $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_idx(string name, rfidx_t got, rfidx_t exp);
      if (got !== exp) begin
         $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // reference model walk over the loaded program
   task automatic build_expected(pc_t start, int n);
      pc_t pc;
      pc = start;
      repeat (n) begin
         exp_pc_q.push_back(pc);
         exp_ir_q.push_back(prog[pc[`IFU_ITCM_AW+1:2]]);
         pc = ref_next_pc(prog[pc[`IFU_ITCM_AW+1:2]], pc);
      end
   endtask

   always @(posedge clk) begin
      case (ready_mode)
         2'd0:    ifu_o_ready <= 1'b0;
         2'd1:    ifu_o_ready <= 1'b1;
         default: ifu_o_ready <= $random(seed) & 1;
      endcase
   end

   // compare every accepted transfer against the expected stream
   always @(posedge clk) begin
      if (rst_n && ifu_o_valid && ifu_o_ready) begin
         if (exp_pc_q.size() == 0) begin
            $display("transfer at %0t with no instruction left in the expected stream", $time);
            err_cnt++;
         end else begin
            e_pc = exp_pc_q.pop_front();
            e_ir = exp_ir_q.pop_front();
            check_pc("ifu_o_pc", ifu_o_pc, e_pc);
            check_instr("ifu_o_ir", ifu_o_ir, e_ir);
            check_idx("ifu_o_rs1idx", ifu_o_rs1idx, ref_rs1(e_ir));
            check_idx("ifu_o_rs2idx", ifu_o_rs2idx, ref_rs2(e_ir));
            check_bit("ifu_o_prdt_taken", ifu_o_prdt_taken, ref_taken(e_ir));
         end
         got_cnt++;
      end
   end

   always @(posedge clk) begin
      if (rst_n) begin
         cycles++;
         if (cycles > LIMIT) begin
            $display("timeout, fetch stopped delivering after %0d cycles", cycles);
            $display("test failed");
            $finish;
         end
      end
   end

   // filler words, decodable and unique per address
   task automatic fill_prog();
      for (int i = 0; i < `IFU_ITCM_DEPTH; i++) begin
         prog[i] = enc_i({4'h0, i[7:0]}, rfidx_t'(i), rfidx_t'(i >> 3), 7'h13);
      end
   endtask

   task automatic load_branch_prog();
      fill_prog();
      prog[0]  = enc_i(12'd1, 5'd2, 5'd3, 7'h13);
      prog[1]  = enc_b(13'd16, 5'd1, 5'd2);       // forward, falls through
      prog[2]  = enc_j(21'h20, 5'd0);             // to 0x28
      prog[8]  = enc_r(5'd9, 5'd10, 5'd11);
      prog[11] = enc_b(13'h1ff4, 5'd3, 5'd4);     // back to 0x20
   endtask

   task automatic restart(logic oitf);
      @(posedge clk);
      rst_n          <= 1'b0;
      ready_mode     <= 2'd0;
      pipe_flush_req <= 1'b0;
      oitf_empty     <= oitf;
      for (int i = 0; i < `IFU_ITCM_DEPTH; i++) begin
         @(posedge clk);
         imem_wr      <= 1'b1;
         imem_wr_addr <= pc_t'(i * 4);
         imem_wr_data <= prog[i];
      end
      @(posedge clk);
      imem_wr <= 1'b0;
      exp_pc_q.delete();
      exp_ir_q.delete();
      got_cnt = 0;
   endtask

   task automatic go(logic [1:0] mode);
      @(posedge clk);
      rst_n      <= 1'b1;
      ready_mode <= mode;
   endtask

   // polled between edges, away from the checker's update
   task automatic wait_got(int n);
      while (got_cnt < n) @(negedge clk);
   endtask

   task automatic end_test(string name, int err_before);
      if (err_cnt == err_before) begin
         pass_cnt++;
         $display("%s: ok, %0d transfers", name, got_cnt);
      end else begin
         fail_cnt++;
         $display("%s: FAILED, %0d errors", name, err_cnt - err_before);
      end
   endtask

   initial begin
      int  e0;
      int  k;
      int  off;
      int  kind;
      pc_t f1;
      pc_t f2;
      seed = 46042;
      rst_n = 1'b0;
      imem_wr = 1'b0;
      imem_wr_addr = '0;
      imem_wr_data = '0;
      ifu_o_ready = 1'b0;
      ready_mode = 2'd0;
      pipe_flush_req = 1'b0;
      pipe_flush_add_op1 = '0;
      pipe_flush_add_op2 = '0;
      oitf_empty = 1'b1;
      dec2ifu_rden = 1'b0;
      dec2ifu_rdidx = '0;
      rf2ifu_x1 = X1_VAL;
      rf2ifu_rs1 = RS1_VAL;

      e0 = err_cnt;
      fill_prog();
      for (int i = 0; i < 16; i++) begin
         prog[i] = i[0] ? enc_r(rfidx_t'(i + 3), rfidx_t'(i), rfidx_t'(i + 1))
                        : enc_i(12'(i * 7), rfidx_t'(i + 5), rfidx_t'(i), 7'h13);
      end
      restart(1'b1);
      build_expected(`IFU_RESET_VEC, 16 + 8);
      go(2'd1);
      wait_got(16);
      end_test("straight_line", e0);

      e0 = err_cnt;
      load_branch_prog();
      restart(1'b1);
      build_expected(`IFU_RESET_VEC, 24 + 8);
      go(2'd1);
      wait_got(24);
      end_test("jal_branch", e0);

      e0 = err_cnt;
      fill_prog();
      prog[1]  = enc_i(12'h040, 5'd0, 5'd0, 7'h67);
      prog[16] = enc_i(12'h008, 5'd1, 5'd0, 7'h67);
      prog[34] = enc_i(12'h004, 5'd5, 5'd0, 7'h67);   // waits on x5
      restart(1'b0);
      build_expected(`IFU_RESET_VEC, 8 + 8);
      go(2'd1);
      wait_got(4);
      repeat (10) @(negedge clk);
      if (got_cnt != 4) begin
         $display("instruction delivered while the JALR operand was still pending");
         err_cnt++;
      end
      @(posedge clk);
      oitf_empty <= 1'b1;
      wait_got(8);
      end_test("jalr", e0);

      e0 = err_cnt;
      load_branch_prog();
      restart(1'b1);
      build_expected(`IFU_RESET_VEC, 24 + 8);
      go(2'd2);
      wait_got(24);
      end_test("back_pressure", e0);

      e0 = err_cnt;
      load_branch_prog();
      restart(1'b1);
      k  = 3 + ({$random(seed)} % 8);
      f1 = pc_t'(({$random(seed)} % 128) * 4 + 32'h100);
      f2 = pc_t'({$random(seed)} % 16);
      build_expected(`IFU_RESET_VEC, k + 8);
      go(2'd1);
      wait_got(k);
      @(posedge clk);
      pipe_flush_req     <= 1'b1;   // same cycle as a transfer and a new request
      pipe_flush_add_op1 <= f1;
      pipe_flush_add_op2 <= f2;
      @(posedge clk);
      check_bit("pipe_flush_ack", pipe_flush_ack, 1'b1);
      pipe_flush_req <= 1'b0;
      @(negedge clk);
      exp_pc_q.delete();
      exp_ir_q.delete();
      build_expected((f1 + f2) & ~pc_t'(3), 12 + 8);
      wait_got(got_cnt + 12);
      end_test("flush", e0);

      e0 = err_cnt;
      fill_prog();
      for (int i = 0; i < 64; i++) begin
         kind = {$random(seed)} % 10;
         off  = (int'({$random(seed)} % 16) - 8) * 4;
         if (off == 0) off = 8;
         if (kind < 6) prog[i] = enc_r(rfidx_t'(kind), rfidx_t'(i), rfidx_t'(i + 2));
         else if (kind < 8) prog[i] = enc_b(13'(off), rfidx_t'(i), rfidx_t'(kind));
         else prog[i] = enc_j(21'(off * 2), rfidx_t'(kind));
      end
      restart(1'b1);
      build_expected(`IFU_RESET_VEC, 60 + 8);
      go(2'd2);
      wait_got(60);
      end_test("random_program", e0);

      $display("summary: %0d ok, %0d failing, %0d errors", pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== verif/ifu_sva.sv ====
`timescale 1ns/100ps

module ifu_sva (
   input logic               clk,
   input logic               rst_n,
   input logic               ifu_req_valid,
   input ifu_pkg::pc_t       ifu_req_pc,
   input logic               ifu_rsp_valid,
   input logic               ifu_o_valid,
   input logic               ifu_o_ready,
   input ifu_pkg::pc_t       ifu_o_pc,
   input ifu_pkg::rv_instr_u ifu_o_ir,
   input ifu_pkg::rfidx_t    ifu_o_rs1idx,
   input ifu_pkg::rfidx_t    ifu_o_rs2idx,
   input logic               ifu_o_prdt_taken,
   input logic               pipe_flush_req
);

   // a flush may drop a stalled entry, anything else must hold
   hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_o_valid && !ifu_o_ready && !pipe_flush_req
      |=> ifu_o_valid && $stable(ifu_o_pc) && $stable(ifu_o_ir)
          && $stable(ifu_o_rs1idx) && $stable(ifu_o_rs2idx)
          && $stable(ifu_o_prdt_taken))
      else $error("fetch output changed while the execute side stalled it");

   single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_req_valid |=> !ifu_req_valid)
      else $error("second request issued while one is outstanding");

   rsp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_req_valid |=> ifu_rsp_valid)
      else $error("memory response missing one cycle after request");

   rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_rsp_valid |-> $past(ifu_req_valid))
      else $error("memory response without a request");

   req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_req_valid |-> ifu_req_pc[1:0] == 2'b00)
      else $error("request address not word aligned");

endmodule

bind ifu_ifetch ifu_sva u_ifu_sva (.*);

// ==== hw/ifu_top.sv ====
`timescale 1ns/100ps

module ifu_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               imem_wr,
   input  ifu_pkg::pc_t       imem_wr_addr,
   input  ifu_pkg::rv_instr_u imem_wr_data,
   output ifu_pkg::rv_instr_u ifu_o_ir,
   output ifu_pkg::pc_t       ifu_o_pc,
   output ifu_pkg::rfidx_t    ifu_o_rs1idx,
   output ifu_pkg::rfidx_t    ifu_o_rs2idx,
   output logic               ifu_o_prdt_taken,
   output logic               ifu_o_valid,
   input  logic               ifu_o_ready,
   output logic               pipe_flush_ack,
   input  logic               pipe_flush_req,
   input  ifu_pkg::pc_t       pipe_flush_add_op1,
   input  ifu_pkg::pc_t       pipe_flush_add_op2,
   input  logic               oitf_empty,
   input  logic               dec2ifu_rden,
   input  ifu_pkg::rfidx_t    dec2ifu_rdidx,
   input  ifu_pkg::xlen_t     rf2ifu_x1,
   input  ifu_pkg::xlen_t     rf2ifu_rs1
);
   import ifu_pkg::*;

   logic      ifu_req_valid;
   pc_t       ifu_req_pc;
   logic      ifu_rsp_valid;
   rv_instr_u ifu_rsp_instr;

   ifu_ifetch u_ifetch (
      .clk                (clk),
      .rst_n              (rst_n),
      .ifu_req_valid      (ifu_req_valid),
      .ifu_req_pc         (ifu_req_pc),
      .ifu_rsp_valid      (ifu_rsp_valid),
      .ifu_rsp_instr      (ifu_rsp_instr),
      .ifu_o_ir           (ifu_o_ir),
      .ifu_o_pc           (ifu_o_pc),
      .ifu_o_rs1idx       (ifu_o_rs1idx),
      .ifu_o_rs2idx       (ifu_o_rs2idx),
      .ifu_o_prdt_taken   (ifu_o_prdt_taken),
      .ifu_o_valid        (ifu_o_valid),
      .ifu_o_ready        (ifu_o_ready),
      .pipe_flush_ack     (pipe_flush_ack),
      .pipe_flush_req     (pipe_flush_req),
      .pipe_flush_add_op1 (pipe_flush_add_op1),
      .pipe_flush_add_op2 (pipe_flush_add_op2),
      .oitf_empty         (oitf_empty),
      .dec2ifu_rden       (dec2ifu_rden),
      .dec2ifu_rdidx      (dec2ifu_rdidx),
      .rf2ifu_x1          (rf2ifu_x1),
      .rf2ifu_rs1         (rf2ifu_rs1)
   );

   // memory is always ready, so no ready wire
   ifu_itcm u_itcm (
      .clk           (clk),
      .rst_n         (rst_n),
      .ifu_req_valid (ifu_req_valid),
      .ifu_req_pc    (ifu_req_pc),
      .imem_wr       (imem_wr),
      .imem_wr_addr  (imem_wr_addr),
      .imem_wr_data  (imem_wr_data),
      .ifu_rsp_valid (ifu_rsp_valid),
      .ifu_rsp_instr (ifu_rsp_instr)
   );

endmodule

// ==== hw/ifu_itcm.sv ====
`timescale 1ns/100ps
`include "ifu_settings.svh"

module ifu_itcm (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               ifu_req_valid,
   input  ifu_pkg::pc_t       ifu_req_pc,
   input  logic               imem_wr,
   input  ifu_pkg::pc_t       imem_wr_addr,
   input  ifu_pkg::rv_instr_u imem_wr_data,
   output logic               ifu_rsp_valid,
   output ifu_pkg::rv_instr_u ifu_rsp_instr
);
   import ifu_pkg::*;

   rv_instr_u               mem [0:`IFU_ITCM_DEPTH-1];
   logic [`IFU_ITCM_AW-1:0] rd_idx;
   logic [`IFU_ITCM_AW-1:0] wr_idx;

   // word index, byte offset dropped
   assign rd_idx = ifu_req_pc[`IFU_ITCM_AW+1:2];
   assign wr_idx = imem_wr_addr[`IFU_ITCM_AW+1:2];

   always_ff @(posedge clk) begin
      if (imem_wr) begin
         mem[wr_idx] <= imem_wr_data;   // load strobe, one word per cycle
      end
      if (ifu_req_valid) begin
         ifu_rsp_instr <= mem[rd_idx];
      end
   end

   // response always one cycle behind the request
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ifu_rsp_valid <= 1'b0;
      end else begin
         ifu_rsp_valid <= ifu_req_valid;
      end
   end

endmodule

// ==== hw/ifu_ifetch.sv ====
`timescale 1ns/100ps
`include "ifu_settings.svh"

module ifu_ifetch (
   input  logic               clk,
   input  logic               rst_n,
   output logic               ifu_req_valid,
   output ifu_pkg::pc_t       ifu_req_pc,
   input  logic               ifu_rsp_valid,
   input  ifu_pkg::rv_instr_u ifu_rsp_instr,
   output ifu_pkg::rv_instr_u ifu_o_ir,
   output ifu_pkg::pc_t       ifu_o_pc,
   output ifu_pkg::rfidx_t    ifu_o_rs1idx,
   output ifu_pkg::rfidx_t    ifu_o_rs2idx,
   output logic               ifu_o_prdt_taken,
   output logic               ifu_o_valid,
   input  logic               ifu_o_ready,
   output logic               pipe_flush_ack,
   input  logic               pipe_flush_req,
   input  ifu_pkg::pc_t       pipe_flush_add_op1,
   input  ifu_pkg::pc_t       pipe_flush_add_op2,
   input  logic               oitf_empty,
   input  logic               dec2ifu_rden,
   input  ifu_pkg::rfidx_t    dec2ifu_rdidx,
   input  ifu_pkg::xlen_t     rf2ifu_x1,
   input  ifu_pkg::xlen_t     rf2ifu_rs1
);
   import ifu_pkg::*;

   logic      reset_req_r;    // reset vector not yet requested
   logic      flush_pend_r;   // flush target not yet requested
   logic      kill_r;         // drop the response now arriving
   logic      out_r;          // request in flight
   logic      succ_pend_r;    // IR word still owes its successor request
   logic      ir_valid_r;
   pc_t       pc_r;           // pc of the last request
   pc_t       flush_pc_r;

   rv_instr_u ir_r;
   pc_t       ir_pc_r;
   rfidx_t    ir_rs1idx_r;
   rfidx_t    ir_rs2idx_r;
   logic      ir_prdt_r;

   rv_instr_u dec_instr;
   logic      dec_rs1en;
   logic      dec_rs2en;
   rfidx_t    dec_rs1idx;
   rfidx_t    dec_rs2idx;
   rfidx_t    dec_jalr_rs1idx;
   logic      dec_jal;
   logic      dec_jalr;
   logic      dec_bxx;
   logic      dec_bjp;
   xlen_t     dec_bjp_imm;

   logic      bpu_wait;
   logic      prdt_taken;
   pc_t       prdt_pc_add_op1;
   pc_t       prdt_pc_add_op2;

   logic      ir_load;
   logic      ifu_o_hsked;
   logic      ir_free;
   logic      req_src;
   logic      dec_i_valid;
   logic      bjp_req;
   pc_t       pc_add_op1;
   pc_t       pc_add_op2;
   pc_t       pc_nxt_pre;

   assign ifu_o_hsked = ir_valid_r & ifu_o_ready;
   assign ir_load     = ifu_rsp_valid & ~kill_r & ~pipe_flush_req;

   // decode the word being loaded, else the one held in IR
   assign dec_instr   = ir_load ? ifu_rsp_instr : ir_r;
   assign dec_i_valid = ir_load | succ_pend_r;

   ifu_minidec u_ifu_minidec (
      .instr           (dec_instr),
      .dec_rs1en       (dec_rs1en),
      .dec_rs2en       (dec_rs2en),
      .dec_rs1idx      (dec_rs1idx),
      .dec_rs2idx      (dec_rs2idx),
      .dec_jalr_rs1idx (dec_jalr_rs1idx),
      .dec_jal         (dec_jal),
      .dec_jalr        (dec_jalr),
      .dec_bxx         (dec_bxx),
      .dec_bjp         (dec_bjp),
      .dec_bjp_imm     (dec_bjp_imm)
   );

   ifu_bpu u_ifu_bpu (
      .clk             (clk),
      .rst_n           (rst_n),
      .pc              (pc_r),
      .dec_jal         (dec_jal),
      .dec_jalr        (dec_jalr),
      .dec_bxx         (dec_bxx),
      .dec_bjp_imm     (dec_bjp_imm),
      .dec_jalr_rs1idx (dec_jalr_rs1idx),
      .dec_i_valid     (dec_i_valid),
      .oitf_empty      (oitf_empty),
      .dec2ifu_rden    (dec2ifu_rden),
      .dec2ifu_rdidx   (dec2ifu_rdidx),
      .rf2bpu_x1       (rf2ifu_x1),
      .rf2bpu_rs1      (rf2ifu_rs1),
      .bpu_wait        (bpu_wait),
      .prdt_taken      (prdt_taken),
      .prdt_pc_add_op1 (prdt_pc_add_op1),
      .prdt_pc_add_op2 (prdt_pc_add_op2)
   );

   // at most one request plus one IR entry in flight
   assign ir_free       = ~ir_valid_r | ifu_o_hsked;
   assign req_src       = reset_req_r | flush_pend_r | succ_pend_r;
   assign ifu_req_valid = req_src & ir_free & ~out_r & ~bpu_wait;

   // next pc: reset vector, flush target, prediction, pc + 4
   assign bjp_req    = dec_bjp & prdt_taken;
   assign pc_add_op1 = reset_req_r  ? pc_t'(`IFU_RESET_VEC) :
                       flush_pend_r ? flush_pc_r :
                       bjp_req      ? prdt_pc_add_op1 :
                                      pc_r;
   assign pc_add_op2 = reset_req_r  ? '0 :
                       flush_pend_r ? '0 :
                       bjp_req      ? prdt_pc_add_op2 :
                                      pc_t'(4);
   assign pc_nxt_pre = pc_add_op1 + pc_add_op2;
   assign ifu_req_pc = {pc_nxt_pre[`IFU_PC_SIZE-1:2], 2'b00};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reset_req_r  <= 1'b1;
         flush_pend_r <= 1'b0;
         kill_r       <= 1'b0;
         out_r        <= 1'b0;
         succ_pend_r  <= 1'b0;
         ir_valid_r   <= 1'b0;
         pc_r         <= `IFU_RESET_VEC;
      end else begin
         out_r  <= ifu_req_valid;
         kill_r <= pipe_flush_req & ifu_req_valid;   // that request fetches the old stream
         if (ifu_req_valid) begin
            reset_req_r <= 1'b0;
            pc_r        <= ifu_req_pc;
         end
         if (pipe_flush_req) begin
            flush_pend_r <= 1'b1;
         end else if (ifu_req_valid & ~reset_req_r) begin
            flush_pend_r <= 1'b0;
         end
         if (pipe_flush_req) begin
            succ_pend_r <= 1'b0;
         end else if (ir_load) begin
            succ_pend_r <= 1'b1;
         end else if (ifu_req_valid) begin
            succ_pend_r <= 1'b0;
         end
         if (pipe_flush_req) begin
            ir_valid_r <= 1'b0;
         end else if (ir_load) begin
            ir_valid_r <= 1'b1;
         end else if (ifu_o_hsked) begin
            ir_valid_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_flush_req) begin
         flush_pc_r <= pipe_flush_add_op1 + pipe_flush_add_op2;   // aligned on use
      end
   end

   // IR only loads when empty, so it holds under back-pressure
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ir_r        <= `IFU_INSTR_NOP;
         ir_pc_r     <= '0;
         ir_rs1idx_r <= '0;
         ir_rs2idx_r <= '0;
         ir_prdt_r   <= 1'b0;
      end else if (ir_load) begin
         ir_r        <= ifu_rsp_instr;
         ir_pc_r     <= pc_r;
         ir_rs1idx_r <= dec_rs1en ? dec_rs1idx : '0;
         ir_rs2idx_r <= dec_rs2en ? dec_rs2idx : '0;
         ir_prdt_r   <= prdt_taken;
      end
   end

   assign ifu_o_ir         = ir_r;
   assign ifu_o_pc         = ir_pc_r;
   assign ifu_o_rs1idx     = ir_rs1idx_r;
   assign ifu_o_rs2idx     = ir_rs2idx_r;
   assign ifu_o_prdt_taken = ir_prdt_r;
   assign ifu_o_valid      = ir_valid_r;
   assign pipe_flush_ack   = 1'b1;   // flush always taken at once

endmodule

// ==== hw/ifu_bpu.sv ====
`timescale 1ns/100ps
`include "ifu_settings.svh"

module ifu_bpu (
   input  logic            clk,
   input  logic            rst_n,
   input  ifu_pkg::pc_t    pc,
   input  logic            dec_jal,
   input  logic            dec_jalr,
   input  logic            dec_bxx,
   input  ifu_pkg::xlen_t  dec_bjp_imm,
   input  ifu_pkg::rfidx_t dec_jalr_rs1idx,
   input  logic            dec_i_valid,
   input  logic            oitf_empty,
   input  logic            dec2ifu_rden,
   input  ifu_pkg::rfidx_t dec2ifu_rdidx,
   input  ifu_pkg::xlen_t  rf2bpu_x1,
   input  ifu_pkg::xlen_t  rf2bpu_rs1,
   output logic            bpu_wait,
   output logic            prdt_taken,
   output ifu_pkg::pc_t    prdt_pc_add_op1,
   output ifu_pkg::pc_t    prdt_pc_add_op2
);
   import ifu_pkg::*;

   logic  jalr_rs1_x0;
   logic  jalr_rs1_x1;
   logic  jalr_rs1_xn;
   logic  jalr_xn_vld;
   logic  rs1_hazard;
   logic  rs1_rd_r;      // hazard gone, rs1 read under way
   xlen_t jalr_base;

   assign jalr_rs1_x0 = dec_jalr & (dec_jalr_rs1idx == rfidx_t'(0));
   assign jalr_rs1_x1 = dec_jalr & (dec_jalr_rs1idx == rfidx_t'(1));
   assign jalr_rs1_xn = dec_jalr & ~jalr_rs1_x0 & ~jalr_rs1_x1;
   assign jalr_xn_vld = dec_i_valid & jalr_rs1_xn;

   // rs1 may still be written by an older instruction
   assign rs1_hazard = ~oitf_empty | (dec2ifu_rden & (dec2ifu_rdidx == dec_jalr_rs1idx));

   // one extra cycle once the hazard clears, then rs1 is taken as final
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rs1_rd_r <= 1'b0;
      end else begin
         rs1_rd_r <= jalr_xn_vld & ~rs1_hazard & ~rs1_rd_r;
      end
   end

   assign bpu_wait = jalr_xn_vld & (rs1_hazard | ~rs1_rd_r);

   // backward branches taken, forward not taken
   assign prdt_taken = dec_i_valid
                     & (dec_jal | dec_jalr | (dec_bxx & dec_bjp_imm[`IFU_XLEN-1]));

   always_comb begin
      if (jalr_rs1_x0) begin
         jalr_base = '0;
      end else if (jalr_rs1_x1) begin
         jalr_base = rf2bpu_x1;
      end else begin
         jalr_base = rf2bpu_rs1;
      end
   end

   assign prdt_pc_add_op1 = dec_jalr ? pc_t'(jalr_base) : pc;   // pc relative otherwise
   assign prdt_pc_add_op2 = pc_t'(dec_bjp_imm);

endmodule

// ==== hw/ifu_minidec.sv ====
`timescale 1ns/100ps
`include "ifu_settings.svh"

module ifu_minidec (
   input  ifu_pkg::rv_instr_u instr,
   output logic               dec_rs1en,
   output logic               dec_rs2en,
   output ifu_pkg::rfidx_t    dec_rs1idx,
   output ifu_pkg::rfidx_t    dec_rs2idx,
   output ifu_pkg::rfidx_t    dec_jalr_rs1idx,
   output logic               dec_jal,
   output logic               dec_jalr,
   output logic               dec_bxx,
   output logic               dec_bjp,
   output ifu_pkg::xlen_t     dec_bjp_imm
);
   import ifu_pkg::*;

   rv_opcode_e opc;
   xlen_t      jal_imm;
   xlen_t      jalr_imm;
   xlen_t      bxx_imm;

   // fold the major opcode into the few classes fetch needs
   always_comb begin
      case (instr.i.opcode)
         OPC_JAL:    opc = OPC_JAL;
         OPC_JALR:   opc = OPC_JALR;
         OPC_BRANCH: opc = OPC_BRANCH;
         default:    opc = OPC_OTHER;
      endcase
   end

   assign dec_jal  = (opc == OPC_JAL);
   assign dec_jalr = (opc == OPC_JALR);
   assign dec_bxx  = (opc == OPC_BRANCH);
   assign dec_bjp  = dec_jal | dec_jalr | dec_bxx;

   // J view, 21 bit offset
   assign jal_imm  = {{(`IFU_XLEN-20){instr.j.imm20}}, instr.j.imm19_12,
                      instr.j.imm11, instr.j.imm10_1, 1'b0};
   assign jalr_imm = {{(`IFU_XLEN-12){instr.i.imm[11]}}, instr.i.imm};   // I view
   // B view, 13 bit offset
   assign bxx_imm  = {{(`IFU_XLEN-12){instr.b.imm12}}, instr.b.imm11,
                      instr.b.imm10_5, instr.b.imm4_1, 1'b0};

   always_comb begin
      case (opc)
         OPC_JAL:    dec_bjp_imm = jal_imm;
         OPC_JALR:   dec_bjp_imm = jalr_imm;
         OPC_BRANCH: dec_bjp_imm = bxx_imm;
         default:    dec_bjp_imm = '0;
      endcase
   end

   // rs1 sits at the same bits in I and B formats
   assign dec_rs1idx      = instr.i.rs1;
   assign dec_rs2idx      = instr.b.rs2;
   assign dec_jalr_rs1idx = instr.i.rs1;

   // jal reads no register, only branches read rs2
   assign dec_rs1en = (opc != OPC_JAL);
   assign dec_rs2en = dec_bxx;

endmodule

// ==== hw/ifu_pkg.sv ====
`include "ifu_settings.svh"

package ifu_pkg;

   typedef logic [`IFU_PC_SIZE-1:0]     pc_t;
   typedef logic [`IFU_XLEN-1:0]        xlen_t;
   typedef logic [`IFU_RFIDX_WIDTH-1:0] rfidx_t;

   // major opcodes the fetch stage cares about
   typedef enum logic [6:0] {
      OPC_BRANCH = 7'b1100011,
      OPC_JALR   = 7'b1100111,
      OPC_JAL    = 7'b1101111,
      OPC_OTHER  = 7'b0010011   // stands for every other major opcode
   } rv_opcode_e;

   typedef struct packed {
      logic [11:0] imm;
      rfidx_t      rs1;
      logic [2:0]  funct3;
      rfidx_t      rd;
      logic [6:0]  opcode;
   } rv_itype_t;

   // branch immediate is scattered over two fields
   typedef struct packed {
      logic        imm12;
      logic [5:0]  imm10_5;
      rfidx_t      rs2;
      rfidx_t      rs1;
      logic [2:0]  funct3;
      logic [3:0]  imm4_1;
      logic        imm11;
      logic [6:0]  opcode;
   } rv_btype_t;

   typedef struct packed {
      logic        imm20;
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      rfidx_t      rd;
      logic [6:0]  opcode;
   } rv_jtype_t;

   // one instruction word, three decodings
   typedef union packed {
      rv_itype_t i;
      rv_btype_t b;
      rv_jtype_t j;
   } rv_instr_u;

endpackage

// ==== hw/ifu_settings.svh ====
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// datapath widths
`define IFU_PC_SIZE      32
`define IFU_XLEN         32
`define IFU_INSTR_SIZE   32
`define IFU_RFIDX_WIDTH  5

// first fetch address after reset
`define IFU_RESET_VEC    32'h0000_0000

// instruction memory geometry, depth in words
`define IFU_ITCM_DEPTH   256
`define IFU_ITCM_AW      8

// addi x0, x0, 0
`define IFU_INSTR_NOP    32'h0000_0013

`endif
